//--- div_core.sv
`timescale 1ns/1ns

module div_core
    import div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder,
    output logic             overflow,
    output logic             busy,
    output logic             done
);

    div_state_t state;

    // unsigned magnitudes of the working values
    logic [WIDTH-1:0] rem_mag;
    logic [WIDTH-1:0] dvs_mag;
    logic [WIDTH-1:0] quo_mag;

    // result signs captured at start
    logic quo_neg;
    logic rem_neg;
    logic ovf;

    // leading-one positions and the chosen shift
    msb_pos_t msb_rem;
    msb_pos_t msb_dvs;
    msb_pos_t msb_rem_q;
    msb_pos_t msb_dvs_q;
    msb_pos_t shift;

    logic [WIDTH-1:0] dividend_abs;
    logic [WIDTH-1:0] divisor_abs;
    msb_pos_t         shift_raw;
    logic [WIDTH-1:0] dvs_raw;
    logic [WIDTH-1:0] dvs_shifted;
    logic [WIDTH-1:0] rem_next;

    // magnitude of the most negative value wraps to its own unsigned bit pattern
    assign dividend_abs = dividend[WIDTH-1] ? -dividend : dividend;
    assign divisor_abs  = divisor[WIDTH-1] ? -divisor : divisor;

    msb_find #(
        .WIDTH(WIDTH)
    ) u_msb_rem (
        .value(rem_mag),
        .pos  (msb_rem)
    );

    msb_find #(
        .WIDTH(WIDTH)
    ) u_msb_dvs (
        .value(dvs_mag),
        .pos  (msb_dvs)
    );

    // align the divisor under the leading one of the remainder
    assign shift_raw   = msb_rem_q - msb_dvs_q;
    assign dvs_raw     = dvs_mag << shift_raw;
    assign dvs_shifted = dvs_mag << shift;
    assign rem_next    = rem_mag - dvs_shifted;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            ovf   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        ovf <= (divisor == '0);
                        if (divisor == '0 || divisor == WIDTH'(1)) begin
                            state <= SHORT;
                        end else if (dividend_abs < divisor_abs) begin
                            // quotient is zero, remainder is the dividend
                            state <= FINISH;
                        end else begin
                            state <= FIND;
                        end
                    end
                end
                SHORT: begin
                    state <= FINISH;
                end
                FIND: begin
                    state <= ALIGN;
                end
                ALIGN: begin
                    state <= SUB;
                end
                SUB: begin
                    // keep going while the divisor still fits
                    if (rem_next >= dvs_mag) begin
                        state <= FIND;
                    end else begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    rem_mag <= dividend_abs;
                    dvs_mag <= divisor_abs;
                    quo_mag <= '0;
                    quo_neg <= dividend[WIDTH-1] ^ divisor[WIDTH-1];
                    rem_neg <= dividend[WIDTH-1];
                end
            end
            SHORT: begin
                // divide by zero or one, quotient is the dividend itself
                quo_mag <= rem_mag;
                rem_mag <= '0;
            end
            FIND: begin
                msb_rem_q <= msb_rem;
                msb_dvs_q <= msb_dvs;
            end
            ALIGN: begin
                shift <= (dvs_raw > rem_mag) ? shift_raw - msb_pos_t'(1) : shift_raw;
            end
            SUB: begin
                quo_mag <= quo_mag + (WIDTH'(1) << shift);
                rem_mag <= rem_next;
            end
            default: begin
            end
        endcase
    end

    // signs applied on the way out, valid while done is high
    assign quotient  = quo_neg ? -quo_mag : quo_mag;
    assign remainder = rem_neg ? -rem_mag : rem_mag;
    assign overflow  = ovf;
    assign busy      = (state != IDLE);
    assign done      = (state == FINISH);

endmodule

//--- div_pkg.sv
package div_pkg;

    // register map, two address bits
    typedef logic [1:0] reg_addr_t;

    // write dividend, read quotient
    localparam reg_addr_t ADDR_DIVIDEND = 2'd0;
    // write divisor, read remainder
    localparam reg_addr_t ADDR_DIVISOR  = 2'd1;
    // bit 0 starts a division
    localparam reg_addr_t ADDR_CTRL     = 2'd2;
    // read only
    localparam reg_addr_t ADDR_STATUS   = 2'd3;

    // status word bit positions
    localparam int ST_BUSY     = 0;
    localparam int ST_DONE     = 1;
    localparam int ST_OVERFLOW = 2;

    // leading-one position, covers widths up to 64
    typedef logic [5:0] msb_pos_t;

    // core FSM states
    typedef enum logic [2:0] {
        IDLE,
        SHORT,
        FIND,
        ALIGN,
        SUB,
        FINISH
    } div_state_t;

endpackage

//--- div_regs.sv
`timescale 1ns/1ns

module div_regs
    import div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  reg_addr_t        addr,
    input  logic [WIDTH-1:0] wdata,
    input  logic             wr_en,
    output logic [WIDTH-1:0] rdata,
    output logic             start,
    output logic [WIDTH-1:0] dividend,
    output logic [WIDTH-1:0] divisor,
    input  logic             busy,
    input  logic             done,
    input  logic [WIDTH-1:0] quotient,
    input  logic [WIDTH-1:0] remainder,
    input  logic             overflow
);

    logic [WIDTH-1:0] quot_q;
    logic [WIDTH-1:0] rem_q;
    logic             done_q;
    logic             ovf_q;
    logic             locked;
    logic             start_wr;
    logic [WIDTH-1:0] status;

    // a pending start pulse counts as busy too
    assign locked   = busy | start;
    assign start_wr = wr_en && (addr == ADDR_CTRL) && wdata[0] && !locked;

    // operand registers
    always_ff @(posedge clk) begin
        if (wr_en && !locked) begin
            if (addr == ADDR_DIVIDEND) begin
                dividend <= wdata;
            end
            if (addr == ADDR_DIVISOR) begin
                divisor <= wdata;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start  <= 1'b0;
            done_q <= 1'b0;
            ovf_q  <= 1'b0;
            quot_q <= '0;
            rem_q  <= '0;
        end else begin
            start <= start_wr;
            if (start_wr) begin
                done_q <= 1'b0;
                ovf_q  <= 1'b0;
            end else if (done) begin
                // results held until the next start
                done_q <= 1'b1;
                ovf_q  <= overflow;
                quot_q <= quotient;
                rem_q  <= remainder;
            end
        end
    end

    always_comb begin
        status              = '0;
        status[ST_BUSY]     = busy;
        status[ST_DONE]     = done_q;
        status[ST_OVERFLOW] = ovf_q;
    end

    // read mux, ctrl reads back as zero
    always_comb begin
        case (addr)
            ADDR_DIVIDEND: rdata = quot_q;
            ADDR_DIVISOR:  rdata = rem_q;
            ADDR_STATUS:   rdata = status;
            default:       rdata = '0;
        endcase
    end

endmodule

//--- div_top.sv
`timescale 1ns/1ns

module div_top
    import div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  reg_addr_t        addr,
    input  logic [WIDTH-1:0] wdata,
    input  logic             wr_en,
    output logic [WIDTH-1:0] rdata
);

    logic             start;
    logic             busy;
    logic             done;
    logic             overflow;
    logic [WIDTH-1:0] dividend;
    logic [WIDTH-1:0] divisor;
    logic [WIDTH-1:0] quotient;
    logic [WIDTH-1:0] remainder;

    div_regs #(
        .WIDTH(WIDTH)
    ) u_regs (
        .clk      (clk),
        .reset    (reset),
        .addr     (addr),
        .wdata    (wdata),
        .wr_en    (wr_en),
        .rdata    (rdata),
        .start    (start),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (busy),
        .done     (done),
        .quotient (quotient),
        .remainder(remainder),
        .overflow (overflow)
    );

    div_core #(
        .WIDTH(WIDTH)
    ) u_core (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .dividend (dividend),
        .divisor  (divisor),
        .quotient (quotient),
        .remainder(remainder),
        .overflow (overflow),
        .busy     (busy),
        .done     (done)
    );

endmodule

//--- list.f
div_pkg.sv
msb_find.sv
div_core.sv
div_regs.sv
div_top.sv
tb_div.sv

//--- msb_find.sv
`timescale 1ns/1ns

module msb_find
    import div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] value,
    output msb_pos_t         pos
);

    // scan upward so the highest set bit wins
    always_comb begin
        pos = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (value[i]) begin
                pos = msb_pos_t'(i);
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# compile and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -f list.f --top-module tb_div -o sim_tb_div

# keep the simulator status out of set -e, the log decides
./obj_dir/sim_tb_div > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1

//--- tb_div.sv
`timescale 1ns/1ns

module tb_div
    import div_pkg::*;
;

    localparam int WIDTH      = 32;
    localparam int CLK_PERIOD = 8;
    // random pairs plus the fixed sign, special and busy cases
    localparam int NUM_DIVS   = 311;
    localparam int TIMEOUT_NS = (NUM_DIVS * 200 + 20) * CLK_PERIOD;

    logic             clk;
    logic             reset;
    reg_addr_t        addr;
    logic [WIDTH-1:0] wdata;
    logic             wr_en;
    logic [WIDTH-1:0] rdata;

    logic [31:0] lfsr_state = 32'd41329;

    div_top #(
        .WIDTH(WIDTH)
    ) uut (
        .clk  (clk),
        .reset(reset),
        .addr (addr),
        .wdata(wdata),
        .wr_en(wr_en),
        .rdata(rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'hB4BC_D35C;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // signed division truncating toward zero, remainder follows the dividend
    function automatic void ref_divide(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                                       output logic [WIDTH-1:0] q, output logic [WIDTH-1:0] r,
                                       output logic ovf);
        longint sa;
        longint sb;
        longint ma;
        longint mb;
        longint mq;
        longint mr;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        if (b == '0) begin
            q   = a;
            r   = '0;
            ovf = 1'b1;
        end else begin
            ma = (sa < 0) ? -sa : sa;
            mb = (sb < 0) ? -sb : sb;
            mq = ma / mb;
            mr = ma % mb;
            // most negative over minus one wraps back to the dividend here
            if ((sa < 0) != (sb < 0)) begin
                mq = -mq;
            end
            if (sa < 0) begin
                mr = -mr;
            end
            q   = WIDTH'(mq);
            r   = WIDTH'(mr);
            ovf = 1'b0;
        end
    endfunction

    task automatic check_word(input string name, input logic [WIDTH-1:0] expected,
                              input logic [WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_status(input string name, input logic exp_busy, input logic exp_done,
                                input logic exp_ovf, input logic [WIDTH-1:0] actual);
        logic [WIDTH-1:0] expected;
        expected              = '0;
        expected[ST_BUSY]     = exp_busy;
        expected[ST_DONE]     = exp_done;
        expected[ST_OVERFLOW] = exp_ovf;
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // one-cycle write strobe, dropped by the next read
    task automatic reg_write(input reg_addr_t a, input logic [WIDTH-1:0] d);
        @(negedge clk);
        addr  = a;
        wdata = d;
        wr_en = 1'b1;
    endtask

    task automatic reg_read(input reg_addr_t a, output logic [WIDTH-1:0] d);
        @(negedge clk);
        wr_en = 1'b0;
        addr  = a;
        #1;
        d = rdata;
    endtask

    task automatic wait_done(output logic [WIDTH-1:0] st);
        do begin
            reg_read(ADDR_STATUS, st);
        end while (st[ST_DONE] !== 1'b1);
    endtask

    // results and final status of the division already started
    task automatic check_results(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        logic [WIDTH-1:0] st;
        logic [WIDTH-1:0] q;
        logic [WIDTH-1:0] r;
        logic [WIDTH-1:0] exp_q;
        logic [WIDTH-1:0] exp_r;
        logic             exp_ovf;
        wait_done(st);
        reg_read(ADDR_DIVIDEND, q);
        reg_read(ADDR_DIVISOR, r);
        ref_divide(a, b, exp_q, exp_r, exp_ovf);
        check_status($sformatf("status for %h / %h", a, b), 1'b0, 1'b1, exp_ovf, st);
        check_word($sformatf("quotient of %h / %h", a, b), exp_q, q);
        check_word($sformatf("remainder of %h / %h", a, b), exp_r, r);
    endtask

    task automatic run_division(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        reg_write(ADDR_DIVIDEND, a);
        reg_write(ADDR_DIVISOR, b);
        reg_write(ADDR_CTRL, WIDTH'(1));
        check_results(a, b);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out before all divisions finished");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] d;
        clk    = 1'b0;
        reset  = 1'b1;
        addr   = ADDR_DIVIDEND;
        wdata  = '0;
        wr_en  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset values
        reg_read(ADDR_STATUS, d);
        check_status("status after reset", 1'b0, 1'b0, 1'b0, d);
        reg_read(ADDR_DIVIDEND, d);
        check_word("quotient after reset", '0, d);
        reg_read(ADDR_DIVISOR, d);
        check_word("remainder after reset", '0, d);

        // random pairs, divisor size varied by a random shift
        for (int i = 0; i < 300; i++) begin
            a = rand_bits(32);
            b = rand_bits(32) >> rand_bits(5);
            if (rand_bits(1) != 0) begin
                b = -b;
            end
            if (b == '0) begin
                b = 32'd5;
            end
            run_division(a, b);
        end

        // fixed sign combinations
        run_division(32'd100, -32'd7);
        run_division(-32'd100, 32'd7);
        run_division(-32'd100, -32'd7);
        run_division(32'd5, -32'd9);
        run_division(-32'd5, 32'd9);

        // zero and one divisors, wrap case
        run_division(32'd12345, 32'd0);
        run_division(-32'd777, 32'd0);
        run_division(-32'd98765, 32'd1);
        run_division(32'h8000_0000, 32'hFFFF_FFFF);

        // writes during a long division must be ignored
        reg_read(ADDR_STATUS, d);
        check_status("status before new start", 1'b0, 1'b1, 1'b0, d);
        reg_write(ADDR_DIVIDEND, 32'h7FFF_FFFF);
        reg_write(ADDR_DIVISOR, 32'd3);
        reg_write(ADDR_CTRL, WIDTH'(1));
        // start pulse cycle, core not yet busy
        reg_read(ADDR_STATUS, d);
        check_status("status after new start", 1'b0, 1'b0, 1'b0, d);
        reg_write(ADDR_DIVIDEND, 32'h0001_2345);
        reg_write(ADDR_CTRL, WIDTH'(1));
        reg_read(ADDR_STATUS, d);
        check_status("status while busy", 1'b1, 1'b0, 1'b0, d);
        check_results(32'h7FFF_FFFF, 32'd3);

        // restart with the held operands only
        reg_write(ADDR_CTRL, WIDTH'(1));
        check_results(32'h7FFF_FFFF, 32'd3);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
